// ==== files.f ====
+incdir+.
flash_pkg.sv
spi_rx.sv
spi_cmd_fsm.sv
flash_array.sv
spi_tx.sv
spi_flash_top.sv
tb_spi_flash.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the SPI flash testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_spi_flash \
    -f files.f -o sim_spi_flash \
    && ./obj_dir/sim_spi_flash | tee sim.log \
    || { echo "Build or run error"; exit 1; }

grep -q "^TESTS PASSED$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tb_spi_flash.sv ====
/*
 * SPI serial flash testbench
 * Drives the SPI pins in mode 0 and keeps a reference model of the
 * memory and the status register. Covers RDID, WEL handling, erase,
 * program with page wrap, block protection, SRWD with w_n and the
 * busy lockout
 */

`timescale 1ns/1ps
`default_nettype none

`include "flash_defines.svh"

module tb_spi_flash;

    // About three times the length of the test sequence
    localparam int CYCLE_LIMIT = 400000;
    localparam int MEM_BYTES   = 1 << `MEM_ABITS;

    logic CSNeg_ipd;
    logic reset;
    logic sck;
    logic si;
    logic cs_n;
    logic w_n;
    logic so;
    logic so_en;

    logic [7:0]  model_mem [MEM_BYTES];
    logic [7:0]  model_sr;
    logic [7:0]  wr_buf [256];
    logic [31:0] rng_state;
    int          cycles;
    int          checks;
    int          errors;

    spi_flash_top i_dut (
        .CSNeg_ipd (CSNeg_ipd),
        .reset     (reset),
        .sck       (sck),
        .si        (si),
        .cs_n      (cs_n),
        .w_n       (w_n),
        .so        (so),
        .so_en     (so_en)
    );

    always #5 CSNeg_ipd = ~CSNeg_ipd;

    always @(posedge CSNeg_ipd)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // BP protects from the top sector down
    function automatic logic sector_protected(input logic [11:0] addr);
        logic [1:0] sect;
        sect = addr[11:10];
        case (model_sr[4:2])
            3'b000:  return 1'b0;
            3'b001:  return sect == 2'd3;
            3'b010:  return sect[1];
            default: return 1'b1;
        endcase
    endfunction

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("[FAIL] %0d ns: %s = %02h, expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge CSNeg_ipd);
        #1;
    endtask

    // Mode 0, si set while sck is low, so sampled just before sck rises
    task automatic shift_bits(input logic [7:0] tx, input int nbits,
                              input logic exp_en, output logic [7:0] rx);
        rx = '0;
        for (int i = 7; i > 7 - nbits; i--)
        begin
            si = tx[i];
            tick(8);
            rx[i] = so;
            // Output enable only in the data phase of a read
            checks++;
            assert (so_en === exp_en)
            else
            begin
                errors++;
                $display("[FAIL] %0d ns: so_en = %b, expected %b", $time, so_en, exp_en);
            end
            sck = 1'b1;
            tick(8);
            sck = 1'b0;
        end
    endtask

    task automatic xfer(input logic [7:0] tx, output logic [7:0] rx);
        shift_bits(tx, 8, 1'b1, rx);
    endtask

    task automatic send(input logic [7:0] tx);
        logic [7:0] ignored;
        shift_bits(tx, 8, 1'b0, ignored);
    endtask

    task automatic select_chip();
        cs_n = 1'b0;
        tick(8);
    endtask

    task automatic deselect_chip();
        tick(8);
        cs_n = 1'b1;
        tick(16);
    endtask

    task automatic send_addr(input logic [11:0] addr);
        send(8'h00);
        send({4'h0, addr[11:8]});
        send(addr[7:0]);
    endtask

    task automatic send_op(input logic [7:0] op);
        select_chip();
        send(op);
        deselect_chip();
    endtask

    task automatic read_status(output logic [7:0] sr);
        select_chip();
        send(`OP_RDSR);
        xfer(8'h00, sr);
        deselect_chip();
    endtask

    task automatic check_status();
        logic [7:0] sr;
        read_status(sr);
        compare_byte("status", sr, model_sr);
    endtask

    // Poll until WIP drops, then the final status must match
    task automatic wait_ready();
        logic [7:0] sr;
        read_status(sr);
        while (sr[0])
            read_status(sr);
        compare_byte("status", sr, model_sr);
    endtask

    task automatic write_enable(input logic en);
        send_op(en ? `OP_WREN : `OP_WRDI);
        model_sr[1] = en;
    endtask

    task automatic write_status(input logic [7:0] value);
        select_chip();
        send(`OP_WRSR);
        send(value);
        deselect_chip();
        // Locked while SRWD is set and w_n is low
        if (model_sr[1] && !(model_sr[7] && !w_n))
            model_sr = {value[7], 2'b00, value[4:2], 2'b00};
        wait_ready();
    endtask

    task automatic fill_random(input int n);
        for (int i = 0; i < n; i++)
            wr_buf[i] = 8'(next_random());
    endtask

    task automatic program_page(input logic [11:0] addr, input int n);
        logic [11:0] a;
        select_chip();
        send(`OP_PP);
        send_addr(addr);
        for (int i = 0; i < n; i++)
            send(wr_buf[i]);
        deselect_chip();
        if (model_sr[1] && !sector_protected(addr))
        begin
            for (int i = 0; i < n; i++)
            begin
                // Offset wraps inside the page, bits only clear
                a = {addr[11:8], addr[7:0] + 8'(i)};
                model_mem[a] = model_mem[a] & wr_buf[i];
            end
            model_sr[1] = 1'b0;
        end
        wait_ready();
    endtask

    task automatic send_erase(input logic [11:0] addr);
        select_chip();
        send(`OP_SE);
        send_addr(addr);
        deselect_chip();
        if (model_sr[1] && !sector_protected(addr))
        begin
            for (int i = 0; i < 1024; i++)
                model_mem[{addr[11:10], 10'(i)}] = 8'hFF;
            model_sr[1] = 1'b0;
        end
    endtask

    task automatic erase_sector(input logic [11:0] addr);
        send_erase(addr);
        wait_ready();
    endtask

    // Linear read, the address wraps at the top of memory
    task automatic read_check(input logic [11:0] addr, input int n);
        logic [7:0]  rx;
        logic [11:0] a;
        select_chip();
        send(`OP_READ);
        send_addr(addr);
        for (int i = 0; i < n; i++)
        begin
            a = addr + 12'(i);
            xfer(8'h00, rx);
            compare_byte($sformatf("so[%03h]", a), rx, model_mem[a]);
        end
        deselect_chip();
    endtask

    // Same span as a program, split where it wraps in the page
    task automatic read_check_page(input logic [11:0] addr, input int n);
        int first;
        first = 256 - addr[7:0];
        if (n <= first)
            read_check(addr, n);
        else
        begin
            read_check(addr, first);
            read_check({addr[11:8], 8'h00}, n - first);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [7:0]  rx;
        logic [7:0]  id_seq [3];
        logic [11:0] addr;
        int          len;
        CSNeg_ipd = 1'b0;
        reset     = 1'b1;
        sck       = 1'b0;
        si        = 1'b0;
        cs_n      = 1'b1;
        w_n       = 1'b1;
        rng_state = 32'd47;
        cycles    = 0;
        checks    = 0;
        errors    = 0;
        model_sr  = 8'h00;
        id_seq    = '{8'h01, 8'h02, 8'h13};
        repeat (4) @(posedge CSNeg_ipd);
        #1;
        reset = 1'b0;
        tick(4);

        // RDID repeats after the third byte
        select_chip();
        send(`OP_RDID);
        for (int i = 0; i < 7; i++)
        begin
            xfer(8'h00, rx);
            compare_byte("so", rx, id_seq[i % 3]);
        end
        deselect_chip();

        write_enable(1'b1);
        check_status();
        write_enable(1'b0);
        check_status();

        // Erase everything first, memory is unknown after reset
        for (int s = 0; s < 4; s++)
        begin
            write_enable(1'b1);
            erase_sector({2'(s), 10'(next_random())});
            read_check({2'(s), 10'(next_random())}, 4);
        end

        // Random programs on four pages, odd ones wrap in the page
        for (int k = 0; k < 8; k++)
        begin
            len        = 2 + int'(next_random() % 31);
            addr[11:8] = 4'(5 * (next_random() % 4));
            addr[7:0]  = (k % 2 == 1) ? 8'(256 - len / 2) : 8'(next_random());
            fill_random(len);
            write_enable(1'b1);
            program_page(addr, len);
            read_check_page(addr, len);
        end
        read_check(12'hFFA, 12);

        // Without WEL neither program nor erase changes anything
        for (int i = 0; i < 8; i++)
            wr_buf[i] = 8'h00;
        program_page(addr, 8);
        erase_sector(addr);
        read_check_page(addr, 8);

        // Block protection with random BP, one round per sector
        for (int r = 0; r < 4; r++)
        begin
            write_enable(1'b1);
            write_status({3'b000, 3'(next_random()), 2'b00});
            write_enable(1'b1);
            erase_sector({2'(r), 10'(next_random())});
            addr = {2'(r), 10'(next_random())};
            read_check(addr, 8);
            fill_random(8);
            write_enable(1'b1);
            program_page(addr, 8);
            read_check_page(addr, 8);
            write_enable(1'b0);
        end
        write_enable(1'b1);
        write_status(8'h00);

        // SRWD with w_n low locks the status register
        write_enable(1'b1);
        write_status(8'h80);
        w_n = 1'b0;
        tick(4);
        write_enable(1'b1);
        write_status(8'h1C);
        w_n = 1'b1;
        tick(4);
        write_enable(1'b1);
        write_status(8'h00);

        // While busy, WIP and WEL show and WREN is refused
        addr = 12'(next_random());
        write_enable(1'b1);
        send_erase(addr);
        read_status(rx);
        compare_byte("status", rx, model_sr | 8'h03);
        send_op(`OP_WREN);
        wait_ready();

        // Program cut off in the middle of a byte
        write_enable(1'b1);
        select_chip();
        send(`OP_PP);
        send_addr(addr);
        send(8'h00);
        shift_bits(8'h00, 3, 1'b0, rx);
        deselect_chip();
        read_check(addr, 4);
        check_status();
        write_enable(1'b0);
        check_status();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== spi_flash_top.sv ====
/*
 * SPI serial flash, top level
 * Receive side, command FSM, flash array and transmit side
 */

`timescale 1ns/1ps
`default_nettype none

module spi_flash_top import flash_pkg::*; (
    input  logic CSNeg_ipd,
    input  logic reset,
    input  logic sck,
    input  logic si,
    input  logic cs_n,
    input  logic w_n,
    output logic so,
    output logic so_en
);

    logic      sel_start;
    logic      sel_end;
    logic      sck_fall;
    logic      byte_valid;
    logic      byte_aligned;
    byte_t     rx_byte;
    instr_e    instr;
    addr_t     cmd_addr;
    mem_addr_t rd_addr;
    byte_t     rd_data;
    status_t   status;
    logic      wr_byte_valid;
    logic      cmd_done;
    logic      tx_load;
    logic      tx_active;
    byte_t     tx_byte;

    spi_rx i_rx (
        .CSNeg_ipd    (CSNeg_ipd),
        .reset        (reset),
        .sck          (sck),
        .si           (si),
        .cs_n         (cs_n),
        .sel_start    (sel_start),
        .sel_end      (sel_end),
        .sck_fall     (sck_fall),
        .byte_valid   (byte_valid),
        .byte_aligned (byte_aligned),
        .rx_byte      (rx_byte)
    );

    spi_cmd_fsm i_fsm (
        .CSNeg_ipd     (CSNeg_ipd),
        .reset         (reset),
        .sel_start     (sel_start),
        .sel_end       (sel_end),
        .byte_valid    (byte_valid),
        .byte_aligned  (byte_aligned),
        .rx_byte       (rx_byte),
        .status        (status),
        .rd_data       (rd_data),
        .instr         (instr),
        .cmd_addr      (cmd_addr),
        .rd_addr       (rd_addr),
        .wr_byte_valid (wr_byte_valid),
        .cmd_done      (cmd_done),
        .tx_load       (tx_load),
        .tx_active     (tx_active),
        .tx_byte       (tx_byte)
    );

    flash_array i_array (
        .CSNeg_ipd     (CSNeg_ipd),
        .reset         (reset),
        .wr_byte_valid (wr_byte_valid),
        .cmd_done      (cmd_done),
        .w_n           (w_n),
        .instr         (instr),
        .cmd_addr      (cmd_addr),
        .rx_byte       (rx_byte),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .status        (status)
    );

    spi_tx i_tx (
        .CSNeg_ipd (CSNeg_ipd),
        .reset     (reset),
        .tx_load   (tx_load),
        .tx_active (tx_active),
        .sck_fall  (sck_fall),
        .sel_end   (sel_end),
        .tx_byte   (tx_byte),
        .so        (so),
        .so_en     (so_en)
    );

endmodule

`default_nettype wire

// ==== spi_tx.sv ====
/*
 * SPI transmit side
 * Shifts the loaded byte out MSB first on each falling sck and
 * drives the output enable for the data phase of a read
 */

`timescale 1ns/1ps
`default_nettype none

module spi_tx import flash_pkg::*; (
    input  logic  CSNeg_ipd,
    input  logic  reset,
    input  logic  tx_load,
    input  logic  tx_active,
    input  logic  sck_fall,
    input  logic  sel_end,
    input  byte_t tx_byte,
    output logic  so,
    output logic  so_en
);

    byte_t shreg;
    logic  shift;

    assign shift = sck_fall && tx_active;

    // Loads land between the eighth and ninth falling sck
    always_ff @(posedge CSNeg_ipd)
    begin
        if (tx_load)
            shreg <= tx_byte;
        else if (shift)
            shreg <= {shreg[6:0], 1'b0};
    end

    always_ff @(posedge CSNeg_ipd)
    begin
        if (reset)
        begin
            so    <= 1'b0;
            so_en <= 1'b0;
        end
        else
        begin
            if (shift)
                so <= shreg[7];
            // Enable holds until the host deselects
            if (sel_end)
                so_en <= 1'b0;
            else if (shift)
                so_en <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== flash_array.sv ====
/*
 * Flash array and write engine
 * Memory, page buffer and status register with block protection;
 * runs page program, sector erase and status write as busy
 * operations that show WIP until they finish
 */

`timescale 1ns/1ps
`default_nettype none

`include "flash_defines.svh"

module flash_array import flash_pkg::*; (
    input  logic      CSNeg_ipd,
    input  logic      reset,
    input  logic      wr_byte_valid,
    input  logic      cmd_done,
    input  logic      w_n,
    input  instr_e    instr,
    input  addr_t     cmd_addr,
    input  byte_t     rx_byte,
    input  mem_addr_t rd_addr,
    output byte_t     rd_data,
    output status_t   status
);

    localparam int MEM_BYTES  = 1 << `MEM_ABITS;
    localparam int PAGE_BYTES = 1 << `PAGE_ABITS;

    byte_t                                  mem [MEM_BYTES];
    byte_t                                  pbuf [PAGE_BYTES];
    logic [`PAGE_ABITS-1:0]                 wr_idx;
    logic [`PAGE_ABITS:0]                   pb_cnt;
    logic [`PAGE_ABITS:0]                   prog_n;
    status_t                                status_q;
    status_t                                sr_new;
    sect_mask_t                             prot;
    core_state_e                            core;
    mem_addr_t                              op_addr;
    mem_addr_t                              pg_addr;
    mem_addr_t                              er_addr;
    logic [`SECTOR_ABITS-1:0]               work_idx;
    logic [5:0]                             busy_cnt;
    logic [`MEM_ABITS-`SECTOR_ABITS-1:0]    cmd_sect;
    logic [1:0]                             w_sync;
    logic                                   srwd_lock;

    // BP protects sectors from the top down
    always_comb
    begin
        case (status_q[4:2])
            3'b000:  prot = 4'b0000;
            3'b001:  prot = 4'b1000;
            3'b010:  prot = 4'b1100;
            default: prot = 4'b1111;
        endcase
    end

    assign cmd_sect  = cmd_addr[`MEM_ABITS-1:`SECTOR_ABITS];
    assign srwd_lock = status_q[7] && !w_sync[1];
    assign status    = status_q;

    // Program stays inside its page, erase walks the whole sector
    assign pg_addr = {op_addr[`MEM_ABITS-1:`PAGE_ABITS],
                      op_addr[`PAGE_ABITS-1:0] + work_idx[`PAGE_ABITS-1:0]};
    assign er_addr = {op_addr[`MEM_ABITS-1:`SECTOR_ABITS], work_idx};

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CSNeg_ipd)
    begin
        w_sync  <= {w_sync[0], w_n};
        rd_data <= mem[rd_addr];
        if (wr_byte_valid)
            pbuf[wr_idx] <= rx_byte;
        // Program can only clear bits
        if (core == PAGE_PG && busy_cnt == '0)
            mem[pg_addr] <= mem[pg_addr] & pbuf[work_idx[`PAGE_ABITS-1:0]];
        else if (core == SECTOR_ER)
            mem[er_addr] <= 8'hFF;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Command execution and write engine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CSNeg_ipd)
    begin
        if (reset)
        begin
            status_q <= '0;
            core     <= IDLE;
            pb_cnt   <= '0;
            wr_idx   <= '0;
            busy_cnt <= '0;
            work_idx <= '0;
        end
        else
        begin
            // Buffer restarts with every new command; extra bytes wrap
            if (instr == NONE)
            begin
                pb_cnt <= '0;
                wr_idx <= '0;
            end
            else if (wr_byte_valid)
            begin
                wr_idx <= wr_idx + 1'b1;
                if (!pb_cnt[`PAGE_ABITS])
                    pb_cnt <= pb_cnt + 1'b1;
            end

            case (core)
                IDLE:
                begin
                    if (cmd_done)
                    begin
                        case (instr)
                            WREN: status_q[1] <= 1'b1;
                            WRDI: status_q[1] <= 1'b0;
                            WRSR:
                            begin
                                if (status_q[1] && pb_cnt != '0 && !srwd_lock)
                                begin
                                    status_q[0] <= 1'b1;
                                    sr_new      <= pbuf[0];
                                    busy_cnt    <= 6'(`WRSR_CYCLES - 1);
                                    core        <= WRITE_SR;
                                end
                            end
                            PP:
                            begin
                                if (status_q[1] && !prot[cmd_sect] && pb_cnt != '0)
                                begin
                                    status_q[0] <= 1'b1;
                                    op_addr     <= mem_addr_t'(cmd_addr);
                                    prog_n      <= pb_cnt;
                                    busy_cnt    <= 6'(`PP_BASE_CYCLES);
                                    work_idx    <= '0;
                                    core        <= PAGE_PG;
                                end
                            end
                            SE:
                            begin
                                if (status_q[1] && !prot[cmd_sect])
                                begin
                                    status_q[0] <= 1'b1;
                                    op_addr     <= mem_addr_t'(cmd_addr);
                                    work_idx    <= '0;
                                    core        <= SECTOR_ER;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                WRITE_SR:
                begin
                    if (busy_cnt != '0)
                        busy_cnt <= busy_cnt - 1'b1;
                    else
                    begin
                        status_q[7]   <= sr_new[7];
                        status_q[4:2] <= sr_new[4:2];
                        status_q[1:0] <= 2'b00;
                        core          <= IDLE;
                    end
                end
                PAGE_PG:
                begin
                    // Fixed delay first, then one byte per cycle
                    if (busy_cnt != '0)
                        busy_cnt <= busy_cnt - 1'b1;
                    else
                    begin
                        work_idx <= work_idx + 1'b1;
                        if (work_idx[`PAGE_ABITS:0] == prog_n - 1'b1)
                        begin
                            status_q[1:0] <= 2'b00;
                            core          <= IDLE;
                        end
                    end
                end
                SECTOR_ER:
                begin
                    work_idx <= work_idx + 1'b1;
                    if (&work_idx)
                    begin
                        status_q[1:0] <= 2'b00;
                        core          <= IDLE;
                    end
                end
                default: core <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== spi_cmd_fsm.sv ====
/*
 * SPI command decoder
 * Bus cycle FSM over code, address and data bytes, instruction
 * decode with the busy lockout, read pointer and the choice of
 * the byte that goes out next
 */

`timescale 1ns/1ps
`default_nettype none

`include "flash_defines.svh"

module spi_cmd_fsm import flash_pkg::*; (
    input  logic      CSNeg_ipd,
    input  logic      reset,
    input  logic      sel_start,
    input  logic      sel_end,
    input  logic      byte_valid,
    input  logic      byte_aligned,
    input  byte_t     rx_byte,
    input  status_t   status,
    input  byte_t     rd_data,
    output instr_e    instr,
    output addr_t     cmd_addr,
    output mem_addr_t rd_addr,
    output logic      wr_byte_valid,
    output logic      cmd_done,
    output logic      tx_load,
    output logic      tx_active,
    output byte_t     tx_byte
);

    bus_state_e state;
    logic [1:0] addr_cnt;
    logic [1:0] id_idx;
    mem_addr_t  rd_ptr;
    logic       load_req;
    logic       load_dly;

    ////////////////////////////////////////////////////////////////////////////
    // Bus cycle FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CSNeg_ipd)
    begin
        if (reset)
        begin
            state    <= STAND_BY;
            instr    <= NONE;
            addr_cnt <= '0;
            id_idx   <= '0;
            rd_ptr   <= '0;
            load_req <= 1'b0;
            load_dly <= 1'b0;
        end
        else
        begin
            load_req <= 1'b0;
            load_dly <= load_req;
            if (sel_end)
                state <= STAND_BY;
            else if (sel_start)
            begin
                state    <= CODE_BYTE;
                instr    <= NONE;
                addr_cnt <= '0;
            end
            else if (byte_valid)
            begin
                case (state)
                    CODE_BYTE:
                    begin
                        // Only RDSR gets through while WIP is set
                        if (status[0] && rx_byte != `OP_RDSR)
                            state <= STAND_BY;
                        else
                        begin
                            state <= DATA_BYTES;
                            case (rx_byte)
                                `OP_WREN: instr <= WREN;
                                `OP_WRDI: instr <= WRDI;
                                `OP_WRSR: instr <= WRSR;
                                `OP_RDSR:
                                begin
                                    instr    <= RDSR;
                                    load_req <= 1'b1;
                                end
                                `OP_RDID:
                                begin
                                    instr    <= RDID;
                                    id_idx   <= '0;
                                    load_req <= 1'b1;
                                end
                                `OP_READ:
                                begin
                                    instr <= READ;
                                    state <= ADDRESS_BYTES;
                                end
                                `OP_PP:
                                begin
                                    instr <= PP;
                                    state <= ADDRESS_BYTES;
                                end
                                `OP_SE:
                                begin
                                    instr <= SE;
                                    state <= ADDRESS_BYTES;
                                end
                                default: state <= STAND_BY;
                            endcase
                        end
                    end
                    ADDRESS_BYTES:
                    begin
                        cmd_addr <= {cmd_addr[15:0], rx_byte};
                        addr_cnt <= addr_cnt + 1'b1;
                        if (addr_cnt == 2'd2)
                        begin
                            state    <= DATA_BYTES;
                            rd_ptr   <= mem_addr_t'({cmd_addr[15:0], rx_byte});
                            load_req <= (instr == READ);
                        end
                    end
                    DATA_BYTES:
                    begin
                        if (tx_active)
                            load_req <= 1'b1;
                        // Pointer wraps from the top of memory to 0
                        if (instr == READ)
                            rd_ptr <= rd_ptr + 1'b1;
                        if (instr == RDID)
                            id_idx <= (id_idx == 2'd2) ? 2'd0 : id_idx + 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // rd_data is valid one cycle after rd_addr, hence the two-stage load
    assign tx_load       = load_dly;
    assign rd_addr       = rd_ptr;
    assign tx_active     = (state == DATA_BYTES) &&
                           (instr == RDSR || instr == RDID || instr == READ);
    assign wr_byte_valid = byte_valid && (state == DATA_BYTES) &&
                           (instr == PP || instr == WRSR);
    assign cmd_done      = sel_end && byte_aligned && (state == DATA_BYTES);

    always_comb
    begin
        case (instr)
            RDSR:    tx_byte = status;
            RDID:
            begin
                case (id_idx)
                    2'd0:    tx_byte = `ID_BYTE0;
                    2'd1:    tx_byte = `ID_BYTE1;
                    default: tx_byte = `ID_BYTE2;
                endcase
            end
            default: tx_byte = rd_data;
        endcase
    end

endmodule

`default_nettype wire

// ==== spi_rx.sv ====
/*
 * SPI receive side
 * Synchronizes sck, si and cs_n to the system clock, makes edge
 * pulses and assembles the incoming bits into bytes, MSB first
 */

`timescale 1ns/1ps
`default_nettype none

module spi_rx import flash_pkg::*; (
    input  logic  CSNeg_ipd,
    input  logic  reset,
    input  logic  sck,
    input  logic  si,
    input  logic  cs_n,
    output logic  sel_start,
    output logic  sel_end,
    output logic  sck_fall,
    output logic  byte_valid,
    output logic  byte_aligned,
    output byte_t rx_byte
);

    logic [1:0] sck_sync;
    logic [1:0] cs_sync;
    logic [1:0] si_sync;
    logic       sck_d;
    logic       cs_d;
    logic       sck_rise;
    bit_cnt_t   bit_cnt;
    logic [6:0] shreg;

    // Two synchronizer stages, then one registered edge pulse
    always_ff @(posedge CSNeg_ipd)
    begin
        if (reset)
        begin
            sck_sync  <= '0;
            cs_sync   <= '1;
            sck_d     <= 1'b0;
            cs_d      <= 1'b1;
            sck_rise  <= 1'b0;
            sck_fall  <= 1'b0;
            sel_start <= 1'b0;
            sel_end   <= 1'b0;
            bit_cnt   <= '0;
        end
        else
        begin
            sck_sync  <= {sck_sync[0], sck};
            cs_sync   <= {cs_sync[0], cs_n};
            sck_d     <= sck_sync[1];
            cs_d      <= cs_sync[1];
            sck_rise  <= sck_sync[1] & ~sck_d;
            sck_fall  <= ~sck_sync[1] & sck_d;
            sel_start <= ~cs_sync[1] & cs_d;
            sel_end   <= cs_sync[1] & ~cs_d;
            if (sel_start)
                bit_cnt <= '0;
            else if (sck_rise && !cs_d)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Data path, si is stable around the rising sck
    always_ff @(posedge CSNeg_ipd)
    begin
        si_sync <= {si_sync[0], si};
        if (sck_rise && !cs_d)
            shreg <= {shreg[5:0], si_sync[1]};
    end

    // Eighth bit completes the byte in the same cycle
    assign byte_valid   = sck_rise && !cs_d && (bit_cnt == 3'd7);
    assign rx_byte      = {shreg, si_sync[1]};
    assign byte_aligned = (bit_cnt == '0);

endmodule

`default_nettype wire

// ==== flash_pkg.sv ====
/*
 * Serial flash types
 * Vector types for bytes, addresses and status, and the enums
 * of the instruction decode, the bus cycle and the write engine
 */

`default_nettype none

`include "flash_defines.svh"

package flash_pkg;

    typedef logic [7:0]            byte_t;
    typedef logic [23:0]           addr_t;
    typedef logic [`MEM_ABITS-1:0] mem_addr_t;
    typedef logic [7:0]            status_t;
    typedef logic [3:0]            sect_mask_t;
    typedef logic [2:0]            bit_cnt_t;

    typedef enum logic [3:0] {
        NONE,
        WREN,
        WRDI,
        RDSR,
        WRSR,
        RDID,
        READ,
        PP,
        SE
    } instr_e;

    typedef enum logic [1:0] {
        STAND_BY,
        CODE_BYTE,
        ADDRESS_BYTES,
        DATA_BYTES
    } bus_state_e;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_SR,
        SECTOR_ER,
        PAGE_PG
    } core_state_e;

endpackage

`default_nettype wire

// ==== flash_defines.svh ====
/*
 * Serial flash constants
 * Memory geometry, command opcodes, identification bytes
 * and the busy times of the write operations
 */

`ifndef FLASH_DEFINES_SVH
`define FLASH_DEFINES_SVH

// Geometry, 4 KB in four 1 KB sectors of 256-byte pages
`define MEM_ABITS       12
`define SECTOR_ABITS    10
`define PAGE_ABITS      8

// Command opcodes
`define OP_WREN         8'h06
`define OP_WRDI         8'h04
`define OP_RDSR         8'h05
`define OP_WRSR         8'h01
`define OP_RDID         8'h9F
`define OP_READ         8'h03
`define OP_PP           8'h02
`define OP_SE           8'hD8

// RDID sequence, repeats after the third byte
`define ID_BYTE0        8'h01
`define ID_BYTE1        8'h02
`define ID_BYTE2        8'h13

// Busy times in clock cycles
`define PP_BASE_CYCLES  16
`define WRSR_CYCLES     32

`endif
